// ==== Bender.yml ====
package:
  name: cache16

export_include_dirs:
  - verilog

sources:
  - verilog/cache_pkg.sv
  - verilog/mem_pkg.sv
  - verilog/cache_ctrl_fsm.sv
  - verilog/cache_array.sv
  - verilog/main_mem.sv
  - verilog/cache_top.sv
  - target: simulation
    files:
      - sim/cache_checker.sv
      - sim/tb_cache.sv

// ==== sim/cache_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cache_cfg.svh"

module cache_checker (
    input  wire logic                   clk,
    input  wire logic                   arst_n,
    input  wire cache_pkg::proc_req_t   proc_req,    // Processor strobes
    input  wire cache_pkg::proc_resp_t  proc_resp,   // DUT answer
    input  wire logic                   exp_hit,     // Hit column of the stimulus row
    output int unsigned                 val_errs,    // Wrong hit or rdata
    output int unsigned                 seq_errs     // Stall, done or latency trouble
);

    import cache_pkg::*;

    localparam int unsigned LINES = 1 << `CACHE_INDEX_W;

    logic [`CACHE_DATA_W-1:0]  model_mem [int];       // Memory as the processor sees it
    logic [`CACHE_TAG_W-1:0]   model_tag [LINES];
    logic [LINES-1:0]          model_valid;
    logic                      pend;                  // Access in flight
    proc_req_t                 pend_req;
    logic                      pend_hit;              // Direct-mapped rule result
    int unsigned               edges;                 // Edges since request

    function automatic logic [`CACHE_DATA_W-1:0] model_read(input int key);
        if (model_mem.exists(key)) begin
            return model_mem[key];
        end
        return '0;                                    // Untouched memory reads zero
    endfunction

    task automatic start_access();
        cache_addr_t a;
        a        = proc_req.addr;
        pend_hit = model_valid[a.index] && (model_tag[a.index] == a.tag);
        if (exp_hit !== pend_hit) begin
            $display("Stimulus row for address %h expects hit %0d, model says %0d",
                     proc_req.addr, exp_hit, pend_hit);
            val_errs++;
        end
        model_valid[a.index] = 1'b1;                  // Line now owned by this tag
        model_tag[a.index]   = a.tag;
        if (proc_req.wr) begin
            model_mem[proc_req.addr] = proc_req.wdata;
        end
        pend_req = proc_req;
        pend     = 1'b1;
        edges    = 0;
    endtask

    task automatic check_response();
        logic [`CACHE_DATA_W-1:0] exp_data;
        exp_data = model_read(pend_req.addr);
        if (proc_resp.hit !== pend_hit) begin
            $display("Fail proc_resp.hit at %h: got %h, expected %h",
                     pend_req.addr, proc_resp.hit, pend_hit);
            val_errs++;
        end
        if (pend_req.rd && (proc_resp.rdata !== exp_data)) begin
            $display("Fail proc_resp.rdata at %h: got %h, expected %h",
                     pend_req.addr, proc_resp.rdata, exp_data);
            val_errs++;
        end
        if (pend_hit && (edges != 2)) begin   // Hit path is IDLE, COMPARE, DONE
            $display("Hit at %h answered after %0d edges instead of 2", pend_req.addr, edges);
            seq_errs++;
        end
    endtask

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            model_valid = '0;
            pend        = 1'b0;
            edges       = 0;
            val_errs    = 0;
            seq_errs    = 0;
        end else begin
            if (pend) begin
                edges++;
                if (proc_resp.done) begin
                    check_response();
                    pend = 1'b0;
                end else if (!proc_resp.stall) begin
                    $display("Stall low before done on access to %h", pend_req.addr);
                    seq_errs++;
                end
            end else if (proc_resp.stall || proc_resp.done) begin
                $display("Stall or done raised with no access in flight");
                seq_errs++;
            end
            if ((proc_req.rd || proc_req.wr) && !proc_resp.stall) begin
                start_access();                       // DUT samples it at this edge
            end
        end
    end

endmodule

`default_nettype wire

// ==== sim/tb_cache.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cache_cfg.svh"

module tb_cache;

    import cache_pkg::*;

    localparam int unsigned N_ROWS  = 19;
    localparam int unsigned TIMEOUT = 200;            // Cycles allowed per access

    typedef struct packed {
        logic                      wr;                // Write else read
        logic [`CACHE_ADDR_W-1:0]  addr;              // Byte address
        logic [`CACHE_DATA_W-1:0]  wdata;
        logic                      hit;               // Expected hit flag
    } stim_row_t;

    logic         clk;
    logic         arst_n;
    proc_req_t    proc_req;
    proc_resp_t   proc_resp;
    logic         exp_hit;
    int unsigned  val_errs;
    int unsigned  seq_errs;
    int unsigned  timeouts;

    // Address is tag[15:11], index[10:3], word[2:1]
    stim_row_t stim_tbl [N_ROWS] = '{
        {1'b0, 16'h0090, 16'h0000, 1'b0},             // Cold read of index 0x12
        {1'b1, 16'h0100, 16'hA5A5, 1'b0},             // Write to empty line
        {1'b0, 16'h0100, 16'h0000, 1'b1},
        {1'b1, 16'h0108, 16'h1111, 1'b0},             // Fill all words of index 0x21
        {1'b1, 16'h010A, 16'h2222, 1'b1},
        {1'b1, 16'h010C, 16'h3333, 1'b1},
        {1'b1, 16'h010E, 16'h4444, 1'b1},
        {1'b0, 16'h0108, 16'h0000, 1'b1},             // Read back each word
        {1'b0, 16'h010A, 16'h0000, 1'b1},
        {1'b0, 16'h010C, 16'h0000, 1'b1},
        {1'b0, 16'h010E, 16'h0000, 1'b1},
        {1'b1, 16'h0908, 16'hBEEF, 1'b0},             // Tag 1 evicts dirty tag 0
        {1'b0, 16'h010A, 16'h0000, 1'b0},             // Old data comes back from memory
        {1'b0, 16'h0908, 16'h0000, 1'b0},
        {1'b0, 16'h010C, 16'h0000, 1'b0},             // Ping-pong of clean tags
        {1'b0, 16'h0908, 16'h0000, 1'b0},
        {1'b0, 16'h010E, 16'h0000, 1'b0},
        {1'b0, 16'h010A, 16'h0000, 1'b1},
        {1'b0, 16'h0090, 16'h0000, 1'b1}              // First line still resident
    };

    cache_top i_cache_top (
        .clk       (clk),
        .arst_n    (arst_n),
        .proc_req  (proc_req),
        .proc_resp (proc_resp)
    );

    cache_checker i_cache_checker (
        .clk       (clk),
        .arst_n    (arst_n),
        .proc_req  (proc_req),
        .proc_resp (proc_resp),
        .exp_hit   (exp_hit),
        .val_errs  (val_errs),
        .seq_errs  (seq_errs)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic apply_row(input stim_row_t row);
        proc_req.rd    = !row.wr;                     // One-cycle strobe
        proc_req.wr    = row.wr;
        proc_req.addr  = row.addr;
        proc_req.wdata = row.wdata;
        exp_hit        = row.hit;
        @(negedge clk);
        proc_req.rd = 1'b0;
        proc_req.wr = 1'b0;
    endtask

    task automatic wait_done(input int row);
        int unsigned n;
        n = 0;
        while (!proc_resp.done && (n < TIMEOUT)) begin
            @(negedge clk);
            n++;
        end
        if (!proc_resp.done) begin
            $display("Row %0d got no done within %0d cycles", row, TIMEOUT);
            timeouts++;
        end
        @(negedge clk);                               // Checker sees done at this edge
    endtask

    initial begin
        arst_n   = 1'b0;
        proc_req = '0;
        exp_hit  = 1'b0;
        timeouts = 0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        repeat (2) @(negedge clk);                    // Idle cycles before first request
        for (int i = 0; i < N_ROWS; i++) begin
            apply_row(stim_tbl[i]);
            wait_done(i);
            if (timeouts != 0) begin
                break;
            end
        end
        $display("Errors: value %0d, sequence %0d, timeout %0d", val_errs, seq_errs, timeouts);
        if ((val_errs == 0) && (seq_errs == 0) && (timeouts == 0)) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/cache_array.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cache_cfg.svh"

module cache_array (
    input  wire logic                   clk,
    input  wire logic                   arst_n,
    input  wire cache_pkg::array_cmd_t  array_cmd,   // Controller command
    output cache_pkg::array_stat_t      array_stat   // Status and read word
);

    localparam int unsigned LINES = 1 << `CACHE_INDEX_W;

    logic [LINES-1:0]          valid_q;                              // Line valid
    logic [LINES-1:0]          dirty_q;                              // Line modified
    logic [`CACHE_TAG_W-1:0]   tag_mem  [LINES];
    logic [`CACHE_DATA_W-1:0]  data_mem [LINES][`CACHE_LINE_WORDS];
    logic [`CACHE_DATA_W-1:0]  rdata_q;                              // Registered read
    logic                      wr_en;
    logic                      rd_en;
    logic                      fill_last;                            // Last fill word
    logic [`CACHE_TAG_W-1:0]   line_tag;

    assign wr_en     = array_cmd.en && array_cmd.wr;
    assign rd_en     = array_cmd.en && !array_cmd.wr;
    assign fill_last = wr_en && array_cmd.fill
                       && (array_cmd.word == ($bits(array_cmd.word))'(`CACHE_LINE_WORDS - 1));
    assign line_tag  = tag_mem[array_cmd.index];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;                                           // Empty cache
            dirty_q <= '0;
        end else begin
            if (fill_last) begin
                valid_q[array_cmd.index] <= 1'b1;
                dirty_q[array_cmd.index] <= 1'b0;                    // Fresh from memory
            end else if (wr_en && array_cmd.set_dirty) begin
                dirty_q[array_cmd.index] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill_last) begin
            tag_mem[array_cmd.index] <= array_cmd.tag;               // New owner of line
        end
        if (wr_en) begin
            data_mem[array_cmd.index][array_cmd.word] <= array_cmd.wdata;
        end
        if (rd_en) begin
            rdata_q <= data_mem[array_cmd.index][array_cmd.word];    // One edge latency
        end
    end

    // Status comes straight from the indexed line
    assign array_stat.valid = valid_q[array_cmd.index];
    assign array_stat.dirty = dirty_q[array_cmd.index];
    assign array_stat.tag   = line_tag;
    assign array_stat.hit   = array_cmd.compare && valid_q[array_cmd.index]
                              && (line_tag == array_cmd.tag);
    assign array_stat.rdata = rdata_q;

endmodule

`default_nettype wire

// ==== verilog/cache_cfg.svh ====
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// Processor address and word widths
`define CACHE_ADDR_W      16
`define CACHE_DATA_W      16

// Address split of tag and index
`define CACHE_TAG_W       5
`define CACHE_INDEX_W     8

// Four 16-bit words per line
`define CACHE_LINE_WORDS  4

// Busy cycles per memory access
`define MEM_LATENCY       4

`endif

// ==== verilog/cache_ctrl_fsm.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cache_cfg.svh"

module cache_ctrl_fsm (
    input  wire logic                  clk,
    input  wire logic                  arst_n,
    input  wire cache_pkg::proc_req_t  proc_req,    // Processor strobes
    input  wire cache_pkg::array_stat_t array_stat, // Tag and data status
    input  wire mem_pkg::mem_resp_t    mem_resp,    // Memory busy and rvalid
    output cache_pkg::proc_resp_t      proc_resp,
    output cache_pkg::array_cmd_t      array_cmd,
    output mem_pkg::mem_req_t          mem_req
);

    import cache_pkg::*;
    import mem_pkg::*;

    localparam int unsigned WSEL_W = $clog2(`CACHE_LINE_WORDS);

    ctrl_state_e        state, nxt_state;
    proc_req_t          req_q;      // Latched request
    logic               hit_q;      // Hit of first compare
    logic [WSEL_W-1:0]  word_cnt;   // Write-back and fill word
    logic               word_adv;   // Step word_cnt
    logic               accept;     // New request taken
    logic               last_word;
    cache_addr_t        wb_addr;    // Old line address
    cache_addr_t        fill_addr;  // New line address

    assign accept    = (state == IDLE || state == DONE) && (proc_req.rd || proc_req.wr);
    assign last_word = (word_cnt == WSEL_W'(`CACHE_LINE_WORDS - 1));
    assign wb_addr   = {array_stat.tag, req_q.addr.index, word_cnt, 1'b0};  // Stored tag
    assign fill_addr = {req_q.addr.tag, req_q.addr.index, word_cnt, 1'b0};

    always_comb begin
        nxt_state       = state;
        word_adv        = 1'b0;
        array_cmd       = '0;
        array_cmd.index = req_q.addr.index;  // Line of the request throughout
        array_cmd.tag   = req_q.addr.tag;
        array_cmd.word  = req_q.addr.word;
        array_cmd.wdata = req_q.wdata;
        mem_req         = '0;
        mem_req.op      = MEM_NOP;
        case (state)
            IDLE, DONE: begin
                if (accept) begin
                    nxt_state = COMPARE;
                end else begin
                    nxt_state = IDLE;
                end
            end
            COMPARE: begin
                array_cmd.en      = 1'b1;
                array_cmd.compare = 1'b1;
                if (array_stat.hit) begin
                    array_cmd.wr        = req_q.wr;  // Write hit stores word
                    array_cmd.set_dirty = req_q.wr;
                    nxt_state           = DONE;      // Read word lands next edge
                end else if (array_stat.valid && array_stat.dirty) begin
                    nxt_state = WB_READ;             // Evict old line first
                end else begin
                    nxt_state = FILL_ISSUE;
                end
            end
            WB_READ: begin
                array_cmd.en   = 1'b1;               // Read old word
                array_cmd.word = word_cnt;
                nxt_state      = WB_ISSUE;
            end
            WB_ISSUE: begin
                if (!mem_resp.busy) begin
                    mem_req.op    = MEM_WRITE;
                    mem_req.addr  = wb_addr;
                    mem_req.wdata = array_stat.rdata;  // Word from WB_READ
                    word_adv      = 1'b1;
                    if (last_word) begin
                        nxt_state = FILL_ISSUE;        // Counter wraps to word 0
                    end else begin
                        nxt_state = WB_READ;
                    end
                end
            end
            FILL_ISSUE: begin
                if (!mem_resp.busy) begin            // Last write may still run
                    mem_req.op   = MEM_READ;
                    mem_req.addr = fill_addr;
                    nxt_state    = FILL_WAIT;
                end
            end
            FILL_WAIT: begin
                if (mem_resp.rvalid) begin
                    array_cmd.en    = 1'b1;
                    array_cmd.wr    = 1'b1;
                    array_cmd.fill  = 1'b1;          // Last word validates line
                    array_cmd.word  = word_cnt;
                    array_cmd.wdata = mem_resp.rdata;
                    word_adv        = 1'b1;
                    if (last_word) begin
                        nxt_state = COMPARE;         // Now hits
                    end else begin
                        nxt_state = FILL_ISSUE;
                    end
                end
            end
            default: begin
                nxt_state = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= IDLE;
            hit_q    <= 1'b0;
            word_cnt <= '0;
        end else begin
            state <= nxt_state;
            if (accept) begin
                hit_q <= 1'b1;                       // Cleared on first miss
            end else if (state == COMPARE && !array_stat.hit) begin
                hit_q <= 1'b0;
            end
            if (accept) begin
                word_cnt <= '0;
            end else if (word_adv) begin
                word_cnt <= word_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= proc_req;                       // Sampled at strobe edge
        end
    end

    assign proc_resp.stall = (state != IDLE) && (state != DONE);
    assign proc_resp.done  = (state == DONE);
    assign proc_resp.hit   = hit_q;
    assign proc_resp.rdata = array_stat.rdata;      // Read from COMPARE

endmodule

`default_nettype wire

// ==== verilog/cache_pkg.sv ====
`default_nettype none

`include "cache_cfg.svh"

package cache_pkg;

    typedef struct packed {
        logic [`CACHE_TAG_W-1:0]               tag;       // Upper address bits
        logic [`CACHE_INDEX_W-1:0]             index;     // Line select
        logic [$clog2(`CACHE_LINE_WORDS)-1:0]  word;      // Word in line
        logic                                  byte_bit;  // Always zero here
    } cache_addr_t;

    typedef struct packed {
        logic                      rd;     // One-cycle read strobe
        logic                      wr;     // One-cycle write strobe
        cache_addr_t               addr;
        logic [`CACHE_DATA_W-1:0]  wdata;
    } proc_req_t;

    typedef struct packed {
        logic                      stall;  // Busy with a request
        logic                      done;   // Access finished
        logic                      hit;    // First compare hit
        logic [`CACHE_DATA_W-1:0]  rdata;  // Valid with done on reads
    } proc_resp_t;

    typedef struct packed {
        logic                                  en;         // Array access
        logic                                  wr;         // Write else read
        logic                                  compare;    // Tag compare enable
        logic                                  set_dirty;  // Write hit marks line
        logic                                  fill;       // Refill word from memory
        logic [`CACHE_INDEX_W-1:0]             index;
        logic [`CACHE_TAG_W-1:0]               tag;
        logic [$clog2(`CACHE_LINE_WORDS)-1:0]  word;
        logic [`CACHE_DATA_W-1:0]              wdata;
    } array_cmd_t;

    typedef struct packed {
        logic                      hit;    // Valid and tag match
        logic                      dirty;
        logic                      valid;
        logic [`CACHE_TAG_W-1:0]   tag;    // Stored tag for write-back
        logic [`CACHE_DATA_W-1:0]  rdata;  // Registered read word
    } array_stat_t;

    typedef enum logic [2:0] {
        IDLE,        // Wait for rd or wr
        COMPARE,     // Tag check
        WB_READ,     // Fetch old word from array
        WB_ISSUE,    // Write old word to memory
        FILL_ISSUE,  // Request new word
        FILL_WAIT,   // Wait for rvalid
        DONE         // Respond to processor
    } ctrl_state_e;

endpackage

`default_nettype wire

// ==== verilog/cache_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cache_cfg.svh"

module cache_top (
    input  wire logic                  clk,
    input  wire logic                  arst_n,
    input  wire cache_pkg::proc_req_t  proc_req,   // Processor port
    output cache_pkg::proc_resp_t      proc_resp
);

    import cache_pkg::*;
    import mem_pkg::*;

    wire array_cmd_t  array_cmd;    // Controller to array
    wire array_stat_t array_stat;   // Array back to controller
    wire mem_req_t    mem_req;      // Controller to memory
    wire mem_resp_t   mem_resp;

    cache_ctrl_fsm i_cache_ctrl_fsm (
        .clk        (clk),
        .arst_n     (arst_n),
        .proc_req   (proc_req),
        .array_stat (array_stat),
        .mem_resp   (mem_resp),
        .proc_resp  (proc_resp),
        .array_cmd  (array_cmd),
        .mem_req    (mem_req)
    );

    cache_array i_cache_array (
        .clk        (clk),
        .arst_n     (arst_n),
        .array_cmd  (array_cmd),
        .array_stat (array_stat)
    );

    main_mem #(
        .LATENCY    (`MEM_LATENCY)
    ) i_main_mem (
        .clk        (clk),
        .arst_n     (arst_n),
        .mem_req    (mem_req),
        .mem_resp   (mem_resp)
    );

endmodule

`default_nettype wire

// ==== verilog/main_mem.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cache_cfg.svh"

module main_mem #(
    parameter int unsigned LATENCY = `MEM_LATENCY    // Busy cycles per access
) (
    input  wire logic               clk,
    input  wire logic               arst_n,
    input  wire mem_pkg::mem_req_t  mem_req,         // One-cycle op
    output mem_pkg::mem_resp_t      mem_resp
);

    import mem_pkg::*;

    localparam int unsigned CNT_W     = $clog2(LATENCY + 1);
    localparam int unsigned MEM_WORDS = 1 << (`CACHE_ADDR_W - 1);  // 32K words

    logic [`CACHE_DATA_W-1:0]  mem [MEM_WORDS];
    logic [CNT_W-1:0]          busy_cnt;     // Cycles left
    logic                      rd_pend;      // Current op is a read
    logic [`CACHE_DATA_W-1:0]  rdata_q;      // Captured at acceptance
    logic [`CACHE_ADDR_W-2:0]  word_addr;
    logic                      accept;

    assign word_addr = mem_req.addr[`CACHE_ADDR_W-1:1];              // Drop byte bit
    assign accept    = (mem_req.op != MEM_NOP) && (busy_cnt == '0);

    // Behavioral contents start at zero
    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy_cnt <= '0;
            rd_pend  <= 1'b0;
        end else if (accept) begin
            busy_cnt <= CNT_W'(LATENCY);                             // Busy from next edge
            rd_pend  <= (mem_req.op == MEM_READ);
        end else if (busy_cnt != '0) begin
            busy_cnt <= busy_cnt - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            if (mem_req.op == MEM_WRITE) begin
                mem[word_addr] <= mem_req.wdata;                     // Takes effect now
            end else begin
                rdata_q <= mem[word_addr];
            end
        end
    end

    assign mem_resp.busy   = (busy_cnt != '0);
    assign mem_resp.rvalid = rd_pend && (busy_cnt == CNT_W'(1));     // Last busy cycle
    assign mem_resp.rdata  = rdata_q;

endmodule

`default_nettype wire

// ==== verilog/mem_pkg.sv ====
`default_nettype none

`include "cache_cfg.svh"

package mem_pkg;

    typedef enum logic [1:0] {
        MEM_NOP   = 2'd0,  // No access
        MEM_READ  = 2'd1,
        MEM_WRITE = 2'd2
    } mem_op_e;

    typedef struct packed {
        mem_op_e                   op;     // One-cycle op pulse
        logic [`CACHE_ADDR_W-1:0]  addr;   // Word aligned byte address
        logic [`CACHE_DATA_W-1:0]  wdata;
    } mem_req_t;

    typedef struct packed {
        logic                      busy;    // Access in progress
        logic                      rvalid;  // Read data pulse
        logic [`CACHE_DATA_W-1:0]  rdata;
    } mem_resp_t;

endpackage

`default_nettype wire

// ==== vlog.f ====
+incdir+verilog
verilog/cache_pkg.sv
verilog/mem_pkg.sv
verilog/cache_ctrl_fsm.sv
verilog/cache_array.sv
verilog/main_mem.sv
verilog/cache_top.sv
sim/cache_checker.sv
sim/tb_cache.sv
